// File: hw/tilt_pkg.sv
// Tilt sensor package: SPI sensor constants, direction codes and segment patterns
`default_nettype none

package tilt_pkg;

  ////////////////////////////////////////
  // SPI framing
  ////////////////////////////////////////
  localparam int BYTE_W      = 8;              // One SPI byte
  localparam int FRAME_BYTES = 3;              // Cmd, address, data

  // Sensor commands and registers
  localparam logic [BYTE_W-1:0] CMD_WRITE      = 8'h0A; // Register write
  localparam logic [BYTE_W-1:0] CMD_READ       = 8'h0B; // Register read
  localparam logic [BYTE_W-1:0] ADDR_POWER_CTL = 8'h2D; // Power control
  localparam logic [BYTE_W-1:0] ADDR_SAMPLE    = 8'h0F; // Tilt sample register
  localparam logic [BYTE_W-1:0] VAL_WAKE       = 8'h0A; // Measure mode on
  localparam logic [BYTE_W-1:0] DUMMY_BYTE     = 8'h94; // Filler while sample shifts in

  ////////////////////////////////////////
  // Tilt decode
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    DIR_LEVEL = 2'd0,
    DIR_LEFT  = 2'd1,
    DIR_RIGHT = 2'd2
  } dir_e;

  localparam logic [3:0] THRESH_RIGHT = 4'd2;  // Positive side needs more than this
  localparam logic [3:0] THRESH_LEFT  = 4'd14; // Negative side needs less than this

  // Seven-segment patterns, active low, bit 6 is segment g
  localparam logic [6:0] SEG_LEVEL = 7'b1000000; // "0"
  localparam logic [6:0] SEG_LEFT  = 7'b1111001; // "1"
  localparam logic [6:0] SEG_RIGHT = 7'b0100100; // "2"
  localparam logic [6:0] SEG_BLANK = 7'b1111111; // All off

  // Sample byte, stored raw and read as sign plus low-nibble magnitude
  typedef struct packed {
    logic       sign;
    logic [2:0] pad;
    logic [3:0] mag;
  } tilt_fields_t;

  typedef union packed {
    logic [BYTE_W-1:0] raw;
    tilt_fields_t      f;
  } tilt_sample_u;

endpackage

`default_nettype wire

// File: hw/spi_byte_engine.sv
// SPI byte engine: shifts one byte out on MOSI and one in from MISO, any SPI mode
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine #(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 2   // Must be 2 or more
) (
  input  wire                          i_Clk,
  input  wire                          i_Rst_L,
  input  wire [tilt_pkg::BYTE_W-1:0]   i_tx_byte,  // Byte for MOSI
  input  wire                          i_tx_dv,    // One-cycle start pulse
  output logic                         o_tx_ready, // Idle, next byte accepted
  output logic                         o_rx_dv,    // One-cycle pulse, byte in
  output logic [tilt_pkg::BYTE_W-1:0]  o_rx_byte,  // Byte from MISO
  output logic                         o_spi_clk,
  input  wire                          i_spi_miso,
  output logic                         o_spi_mosi
);

  localparam logic CPOL  = (SPI_MODE == 2) || (SPI_MODE == 3); // Clock idles high
  localparam logic CPHA  = (SPI_MODE == 1) || (SPI_MODE == 3); // Data out on leading edge
  localparam int   CNT_W = $clog2(CLKS_PER_HALF_BIT * 2);
  localparam int   BIT_W = $clog2(tilt_pkg::BYTE_W);

  logic [CNT_W-1:0]            r_clk_count; // Position within one SPI period
  logic                        r_spi_clk;   // Undelayed SPI clock
  logic [4:0]                  r_edges;     // Edges left in this byte
  logic                        r_leading;
  logic                        r_trailing;
  logic                        r_tx_dv;     // Start pulse, one cycle late
  logic [tilt_pkg::BYTE_W-1:0] r_tx_byte;
  logic [BIT_W-1:0]            r_tx_bit;
  logic [BIT_W-1:0]            r_rx_bit;
  logic                        w_shift_edge;
  logic                        w_sample_edge;

  // Out side changes on one edge, in side samples on the other
  assign w_shift_edge  = (r_leading & CPHA) | (r_trailing & ~CPHA);
  assign w_sample_edge = (r_leading & ~CPHA) | (r_trailing & CPHA);

  ////////////////////////////////////////
  // SPI clock and edge strobes
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_tx_ready  <= 1'b0;
      r_edges     <= '0;
      r_leading   <= 1'b0;
      r_trailing  <= 1'b0;
      r_spi_clk   <= CPOL;                 // Idle level
      r_clk_count <= '0;
    end
    else
    begin
      r_leading  <= 1'b0;                  // Strobes last one cycle
      r_trailing <= 1'b0;
      if (i_tx_dv)
      begin
        o_tx_ready <= 1'b0;
        r_edges    <= 5'd16;               // 8 bits, 2 edges each
      end
      else if (r_edges != '0)
      begin
        o_tx_ready <= 1'b0;
        if (r_clk_count == CNT_W'(CLKS_PER_HALF_BIT * 2 - 1))
        begin
          r_edges     <= r_edges - 5'd1;
          r_trailing  <= 1'b1;
          r_clk_count <= '0;
          r_spi_clk   <= ~r_spi_clk;
        end
        else if (r_clk_count == CNT_W'(CLKS_PER_HALF_BIT - 1))
        begin
          r_edges     <= r_edges - 5'd1;
          r_leading   <= 1'b1;
          r_clk_count <= r_clk_count + 1'b1;
          r_spi_clk   <= ~r_spi_clk;
        end
        else
          r_clk_count <= r_clk_count + 1'b1;
      end
      else
        o_tx_ready <= 1'b1;                // Byte done or never started
    end
  end

  // Hold the byte so the caller may change its input
  always_ff @(posedge i_Clk)
  begin
    if (i_tx_dv)
      r_tx_byte <= i_tx_byte;
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      r_tx_dv <= 1'b0;
    else
      r_tx_dv <= i_tx_dv;
  end

  ////////////////////////////////////////
  // MOSI, MSB first
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_spi_mosi <= 1'b0;
      r_tx_bit   <= BIT_W'(tilt_pkg::BYTE_W - 1);
    end
    else if (o_tx_ready)
      r_tx_bit <= BIT_W'(tilt_pkg::BYTE_W - 1); // Rearm for next byte
    else if (r_tx_dv && !CPHA)
    begin
      // CPHA 0: first bit must be on the line before the first edge
      o_spi_mosi <= r_tx_byte[tilt_pkg::BYTE_W-1];
      r_tx_bit   <= BIT_W'(tilt_pkg::BYTE_W - 2);
    end
    else if (w_shift_edge)
    begin
      o_spi_mosi <= r_tx_byte[r_tx_bit];
      r_tx_bit   <= r_tx_bit - 1'b1;
    end
  end

  ////////////////////////////////////////
  // MISO capture
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_rx_dv  <= 1'b0;
      r_rx_bit <= BIT_W'(tilt_pkg::BYTE_W - 1);
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (o_tx_ready)
        r_rx_bit <= BIT_W'(tilt_pkg::BYTE_W - 1);
      else if (w_sample_edge)
      begin
        r_rx_bit <= r_rx_bit - 1'b1;
        if (r_rx_bit == '0)
          o_rx_dv <= 1'b1;                 // Last bit in this cycle
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (!o_tx_ready && w_sample_edge)
      o_rx_byte[r_rx_bit] <= i_spi_miso;
  end

  // One cycle of delay lines the clock up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_spi_clk <= CPOL;
    else
      o_spi_clk <= r_spi_clk;
  end

endmodule

`default_nettype wire

// File: hw/spi_cs_framer.sv
// SPI chip-select framer: holds CS low over a counted group of bytes, then a gap
`timescale 1ns/1ps
`default_nettype none

module spi_cs_framer #(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 2,
  parameter int MAX_BYTES_PER_CS  = 2,
  parameter int CS_INACTIVE_CLKS  = 1
) (
  input  wire                                   i_Clk,
  input  wire                                   i_Rst_L,
  input  wire [$clog2(MAX_BYTES_PER_CS+1)-1:0]  i_tx_count, // Bytes in this frame
  input  wire [tilt_pkg::BYTE_W-1:0]            i_tx_byte,
  input  wire                                   i_tx_dv,
  output logic                                  o_tx_ready,
  output logic                                  o_rx_dv,
  output logic [tilt_pkg::BYTE_W-1:0]           o_rx_byte,
  output logic                                  o_spi_clk,
  input  wire                                   i_spi_miso,
  output logic                                  o_spi_mosi,
  output logic                                  o_spi_cs_n
);

  localparam int CNT_W = $clog2(MAX_BYTES_PER_CS + 1);
  localparam int GAP_W = $clog2(CS_INACTIVE_CLKS + 1);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_TRANSFER = 2'd1;
  localparam logic [1:0] ST_CS_GAP   = 2'd2;

  logic [1:0]       r_state;
  logic [CNT_W-1:0] r_bytes_left;   // Bytes still to start after the current one
  logic [GAP_W-1:0] r_gap_count;
  logic             w_engine_ready;

  spi_byte_engine #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
  ) u_engine (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_byte  (i_tx_byte),
    .i_tx_dv    (i_tx_dv),
    .o_tx_ready (w_engine_ready),
    .o_rx_dv    (o_rx_dv),
    .o_rx_byte  (o_rx_byte),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi)
  );

  ////////////////////////////////////////
  // CS state machine
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state      <= ST_IDLE;
      o_spi_cs_n   <= 1'b1;
      r_bytes_left <= '0;
      r_gap_count  <= GAP_W'(CS_INACTIVE_CLKS);
    end
    else
    begin
      case (r_state)
        ST_IDLE:
        begin
          if (i_tx_dv)                            // First byte opens the frame
          begin
            r_bytes_left <= i_tx_count - 1'b1;
            o_spi_cs_n   <= 1'b0;
            r_state      <= ST_TRANSFER;
          end
        end
        ST_TRANSFER:
        begin
          if (w_engine_ready)
          begin
            if (r_bytes_left != '0)
            begin
              if (i_tx_dv)
                r_bytes_left <= r_bytes_left - 1'b1;
            end
            else
            begin
              o_spi_cs_n  <= 1'b1;               // Frame done
              r_gap_count <= GAP_W'(CS_INACTIVE_CLKS);
              r_state     <= ST_CS_GAP;
            end
          end
        end
        ST_CS_GAP:
        begin
          if (r_gap_count != '0)
            r_gap_count <= r_gap_count - 1'b1;
          else
            r_state <= ST_IDLE;
        end
        default:
        begin
          o_spi_cs_n <= 1'b1;
          r_state    <= ST_IDLE;
        end
      endcase
    end
  end

  // No ready past the last byte of a frame, none during the gap
  assign o_tx_ready = ((r_state == ST_IDLE) |
                       ((r_state == ST_TRANSFER) & w_engine_ready & (r_bytes_left != '0)))
                      & ~i_tx_dv;

endmodule

`default_nettype wire

// File: hw/accel_sequencer.sv
// Accelerometer sequencer: one wake frame, then endless read frames of the tilt sample
`timescale 1ns/1ps
`default_nettype none

module accel_sequencer (
  input  wire                                        i_Clk,
  input  wire                                        i_Rst_L,
  input  wire                                        i_enable,   // Starts the wake frame
  input  wire                                        i_tx_ready,
  output logic                                       o_tx_dv,
  output logic [tilt_pkg::BYTE_W-1:0]                o_tx_byte,
  output logic [$clog2(tilt_pkg::FRAME_BYTES+1)-1:0] o_tx_count,
  input  wire                                        i_rx_dv,
  input  wire  [tilt_pkg::BYTE_W-1:0]                i_rx_byte,
  output tilt_pkg::tilt_sample_u                     o_sample    // Last tilt sample
);

  localparam int COUNT_W = $clog2(tilt_pkg::FRAME_BYTES + 1);
  localparam int IDX_W   = $clog2(tilt_pkg::FRAME_BYTES);

  localparam logic [1:0] ST_IDLE = 2'd0; // Waiting for enable
  localparam logic [1:0] ST_LOAD = 2'd1; // Send next byte once ready
  localparam logic [1:0] ST_GAP  = 2'd2; // Let ready drop after the pulse
  localparam logic [1:0] ST_WAIT = 2'd3; // Byte in flight

  logic [1:0]                  r_state;
  logic [IDX_W-1:0]            r_idx;       // Byte within the frame
  logic                        r_reading;   // 0 wake frame, 1 read frames
  logic [tilt_pkg::BYTE_W-1:0] w_next_byte;
  logic                        w_last;

  assign w_last = (r_idx == IDX_W'(tilt_pkg::FRAME_BYTES - 1));

  // Frame contents
  always_comb
  begin
    w_next_byte = tilt_pkg::DUMMY_BYTE;
    if (!r_reading)
    begin
      case (r_idx)
        2'd0:    w_next_byte = tilt_pkg::CMD_WRITE;
        2'd1:    w_next_byte = tilt_pkg::ADDR_POWER_CTL;
        default: w_next_byte = tilt_pkg::VAL_WAKE;
      endcase
    end
    else
    begin
      case (r_idx)
        2'd0:    w_next_byte = tilt_pkg::CMD_READ;
        2'd1:    w_next_byte = tilt_pkg::ADDR_SAMPLE;
        default: w_next_byte = tilt_pkg::DUMMY_BYTE; // Sample shifts in here
      endcase
    end
  end

  ////////////////////////////////////////
  // Byte stepping
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state   <= ST_IDLE;
      r_idx     <= '0;
      r_reading <= 1'b0;
      o_tx_dv   <= 1'b0;
    end
    else
    begin
      o_tx_dv <= 1'b0;                           // Single-cycle pulse
      case (r_state)
        ST_IDLE:
          if (i_enable)
            r_state <= ST_LOAD;
        ST_LOAD:
          if (i_tx_ready)
          begin
            o_tx_dv <= 1'b1;
            r_state <= ST_GAP;
          end
        ST_GAP:
          r_state <= ST_WAIT;
        ST_WAIT:
          if (i_tx_ready)                        // Byte done, or frame gap over
          begin
            r_state <= ST_LOAD;
            if (w_last)
            begin
              r_idx     <= '0;
              r_reading <= 1'b1;                 // Wake only once
            end
            else
              r_idx <= r_idx + 1'b1;
          end
        default:
          r_state <= ST_IDLE;
      endcase
    end
  end

  // Byte and count go out with the pulse
  always_ff @(posedge i_Clk)
  begin
    if (r_state == ST_LOAD && i_tx_ready)
    begin
      o_tx_byte <= w_next_byte;
      if (r_idx == '0)
        o_tx_count <= COUNT_W'(tilt_pkg::FRAME_BYTES);
    end
  end

  // Keep what came back during the dummy byte
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_sample.raw <= '0;
    else if (i_rx_dv && r_reading && w_last)
      o_sample.raw <= i_rx_byte;
  end

endmodule

`default_nettype wire

// File: hw/tilt_display.sv
// Tilt display: decodes a sample into a direction and drives the seven-segment digit
`timescale 1ns/1ps
`default_nettype none

module tilt_display (
  input  wire tilt_pkg::tilt_sample_u i_sample,
  output tilt_pkg::dir_e              o_turn,   // 2 right, 1 left, 0 level
  output logic [6:0]                  o_hex0    // Active low
);

  ////////////////////////////////////////
  // Tilt rule
  ////////////////////////////////////////
  always_comb
  begin
    // Only the low nibble counts as magnitude
    if (!i_sample.f.sign && (i_sample.f.mag > tilt_pkg::THRESH_RIGHT))
      o_turn = tilt_pkg::DIR_RIGHT;
    else if (i_sample.f.sign && (i_sample.f.mag < tilt_pkg::THRESH_LEFT))
      o_turn = tilt_pkg::DIR_LEFT;
    else
      o_turn = tilt_pkg::DIR_LEVEL;           // Small tilt either way
  end

  // Digit for the code
  always_comb
  begin
    case (o_turn)
      tilt_pkg::DIR_LEVEL: o_hex0 = tilt_pkg::SEG_LEVEL;
      tilt_pkg::DIR_LEFT:  o_hex0 = tilt_pkg::SEG_LEFT;
      tilt_pkg::DIR_RIGHT: o_hex0 = tilt_pkg::SEG_RIGHT;
      default:             o_hex0 = tilt_pkg::SEG_BLANK; // Code 3 is unused
    endcase
  end

endmodule

`default_nettype wire

// File: hw/tilt_sensor_top.sv
// Tilt sensor top: sequencer, SPI framer and display for an SPI accelerometer
`timescale 1ns/1ps
`default_nettype none

module tilt_sensor_top #(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 500000,   // Slow SPI clock for the sensor
  parameter int CS_INACTIVE_CLKS  = 1
) (
  input  wire             i_Clk,
  input  wire             i_Rst_L,
  input  wire             i_Enable,
  input  wire             i_spi_miso,
  output logic            o_spi_clk,
  output logic            o_spi_mosi,
  output logic            o_spi_cs_n,
  output tilt_pkg::dir_e  o_turn,
  output logic [6:0]      o_hex0
);

  localparam int MAX_BYTES_PER_CS = tilt_pkg::FRAME_BYTES;
  localparam int COUNT_W          = $clog2(MAX_BYTES_PER_CS + 1);

  ////////////////////////////////////////
  // Sequencer to framer handshake
  ////////////////////////////////////////
  logic                        tx_dv;
  logic [tilt_pkg::BYTE_W-1:0] tx_byte;
  logic [COUNT_W-1:0]          tx_count;
  logic                        tx_ready;
  logic                        rx_dv;
  logic [tilt_pkg::BYTE_W-1:0] rx_byte;
  tilt_pkg::tilt_sample_u      sample;   // Latest tilt byte

  accel_sequencer u_seq (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_enable   (i_Enable),
    .i_tx_ready (tx_ready),
    .o_tx_dv    (tx_dv),
    .o_tx_byte  (tx_byte),
    .o_tx_count (tx_count),
    .i_rx_dv    (rx_dv),
    .i_rx_byte  (rx_byte),
    .o_sample   (sample)
  );

  spi_cs_framer #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT),
    .MAX_BYTES_PER_CS  (MAX_BYTES_PER_CS),
    .CS_INACTIVE_CLKS  (CS_INACTIVE_CLKS)
  ) u_framer (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_count (tx_count),
    .i_tx_byte  (tx_byte),
    .i_tx_dv    (tx_dv),
    .o_tx_ready (tx_ready),
    .o_rx_dv    (rx_dv),
    .o_rx_byte  (rx_byte),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi),
    .o_spi_cs_n (o_spi_cs_n)
  );

  tilt_display u_display (
    .i_sample (sample),
    .o_turn   (o_turn),
    .o_hex0   (o_hex0)
  );

endmodule

`default_nettype wire

// File: testbench/tilt_sensor_props.sv
// Tilt sensor properties: SPI clock idle while deselected, legal direction and digit codes
`timescale 1ns/1ps
`default_nettype none

module tilt_sensor_props (
  input wire       i_Clk,
  input wire       i_Rst_L,
  input wire       i_spi_clk,
  input wire       i_spi_cs_n,
  input wire [1:0] i_turn,
  input wire [6:0] i_hex0
);

  localparam logic [6:0] DIGIT_0 = 7'b1000000;
  localparam logic [6:0] DIGIT_1 = 7'b1111001;
  localparam logic [6:0] DIGIT_2 = 7'b0100100;
  localparam logic [6:0] BLANK   = 7'b1111111;

  // Mode 0 clock rests low between frames
  a_clk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_spi_cs_n |-> !i_spi_clk)
    else $error("SPI clock high while chip select is high");

  a_turn_code: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_turn != 2'd3)                       // Code 3 never decoded
    else $error("Direction code 3 on o_turn");

  a_hex_pattern: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    (i_hex0 == DIGIT_0) || (i_hex0 == DIGIT_1) || (i_hex0 == DIGIT_2) || (i_hex0 == BLANK))
    else $error("Segment pattern outside the digit table");

endmodule

`default_nettype wire

// File: testbench/tb_tilt_sensor.sv
// Tilt sensor testbench: mode 0 SPI sensor model, file-driven tilt checks and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_tilt_sensor;

  localparam int CLK_PERIOD_NS     = 100;
  localparam int CLKS_PER_HALF_BIT = 4;   // Fast SPI clock for simulation
  localparam int RESET_CYCLES      = 4;
  localparam int IDLE_CYCLES       = 200; // Enable held low this long
  localparam int MAX_TESTS         = 64;
  localparam int COLS              = 3;   // Sample, direction, segments

  logic        i_Clk;
  logic        i_Rst_L;
  logic        i_Enable;
  logic        spi_miso = 1'b0;           // Driven by the sensor model
  logic        spi_clk;
  logic        spi_mosi;
  logic        spi_cs_n;
  logic [1:0]  turn;
  logic [6:0]  hex0;

  logic [15:0] tests_mem [0:COLS*MAX_TESTS-1];
  int          num_tests    = 0;
  bit          tests_loaded = 1'b0;

  ////////////////////////////////////////
  // Sensor model state
  ////////////////////////////////////////
  logic        prev_spi_clk = 1'b0;
  logic        prev_cs_n    = 1'b1;
  int          bit_count    = 0;          // Rising SPI edges in this frame
  logic [7:0]  mosi_shift   = 8'h00;
  logic [7:0]  frame_q [$];               // MOSI bytes of this frame
  int          frames_done  = 0;          // Frame 0 is the wake frame

  tilt_sensor_top #(
    .SPI_MODE          (0),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT),
    .CS_INACTIVE_CLKS  (1)
  ) u_dut (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_Enable   (i_Enable),
    .i_spi_miso (spi_miso),
    .o_spi_clk  (spi_clk),
    .o_spi_mosi (spi_mosi),
    .o_spi_cs_n (spi_cs_n),
    .o_turn     (turn),
    .o_hex0     (hex0)
  );

  bind tilt_sensor_top tilt_sensor_props u_props (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_spi_clk  (o_spi_clk),
    .i_spi_cs_n (o_spi_cs_n),
    .i_turn     (o_turn),
    .i_hex0     (o_hex0)
  );

  always #(CLK_PERIOD_NS/2) i_Clk = ~i_Clk;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    assert (actual === expected)
    else
    begin
      $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic require_true(input bit cond, input string what);
    assert (cond)
    else
    begin
      $display("ERROR time=%0t %s", $time, what);
      abort_run();
    end
  endtask

  // Sensor protocol bytes, wake frame or read frame
  function automatic logic [7:0] expected_mosi(input bit wake, input int idx);
    case (idx)
      0:       return wake ? 8'h0A : 8'h0B;  // Write or read command
      1:       return wake ? 8'h2D : 8'h0F;  // Power control or sample register
      default: return wake ? 8'h0A : 8'h94;  // Wake value or dummy
    endcase
  endfunction

  task automatic verify_frame();
    int idx;
    bit wake;
    wake = (frames_done == 0);
    require_true(bit_count == 24, $sformatf("frame %0d had %0d SPI clocks instead of 24",
                                            frames_done, bit_count));
    for (int i = 0; i < 3; i++)
      compare_value($sformatf("o_spi_mosi byte %0d", i), expected_mosi(wake, i), frame_q[i]);
    if (!wake && frames_done <= num_tests)
    begin
      idx = COLS * (frames_done - 1);        // Line of this frame's sample
      compare_value("o_turn", tests_mem[idx+1], turn);
      compare_value("o_hex0", tests_mem[idx+2], hex0);
    end
  endtask

  ////////////////////////////////////////
  // Mode 0 sensor, seen on falling i_Clk
  ////////////////////////////////////////
  always @(negedge i_Clk)
  begin
    if (i_Rst_L)
    begin
      if (prev_cs_n && !spi_cs_n)                     // Frame opens
      begin
        bit_count = 0;
        frame_q.delete();
      end
      if (!spi_cs_n && spi_clk && !prev_spi_clk)      // Sensor samples MOSI on the rise
      begin
        mosi_shift = {mosi_shift[6:0], spi_mosi};
        bit_count++;
        if (bit_count % 8 == 0)
          frame_q.push_back(mosi_shift);
      end
      if (!spi_cs_n && !spi_clk && prev_spi_clk)      // Next MISO bit on the fall
      begin
        if (frames_done > 0 && frames_done <= num_tests && bit_count >= 16 && bit_count < 24)
          spi_miso = tests_mem[COLS*(frames_done-1)][23-bit_count]; // Sample MSB first
        else
          spi_miso = 1'b0;
      end
      if (!prev_cs_n && spi_cs_n)                     // Frame closes
      begin
        verify_frame();
        frames_done++;
      end
      prev_cs_n    = spi_cs_n;
      prev_spi_clk = spi_clk;
    end
  end

  initial
  begin
    i_Clk    = 1'b0;
    i_Rst_L  = 1'b0;
    i_Enable = 1'b0;
    // No-data marker in every word, upper byte never zero
    for (int a = 0; a < COLS*MAX_TESTS; a++)
      tests_mem[a] = {4'hE, 12'(a)};
    $readmemh("testbench/tilt_tests.txt", tests_mem);
    while (num_tests < MAX_TESTS && tests_mem[COLS*num_tests][15:8] == 8'h00)
      num_tests++;
    require_true(num_tests > 0, "no test lines found in testbench/tilt_tests.txt");
    tests_loaded = 1'b1;

    repeat (RESET_CYCLES) @(negedge i_Clk);
    i_Rst_L = 1'b1;
    @(negedge i_Clk);
    compare_value("o_spi_cs_n", 16'h1, spi_cs_n);   // Idle state after reset
    compare_value("o_turn", 16'h0, turn);
    compare_value("o_hex0", 16'h40, hex0);

    // No frame may start before enable
    repeat (IDLE_CYCLES)
    begin
      @(negedge i_Clk);
      require_true(spi_cs_n, "o_spi_cs_n fell while i_Enable was low");
    end
    i_Enable = 1'b1;

    wait (frames_done == num_tests + 1);             // Wake frame plus one per line
    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog sized from the number of test lines
  initial
  begin
    int limit_cycles;
    wait (tests_loaded);
    limit_cycles = (num_tests + 2) * 3 * 20 * CLKS_PER_HALF_BIT * 2;
    repeat (limit_cycles) @(posedge i_Clk);
    $display("ERROR time=%0t watchdog expired, %0d of %0d frames checked",
             $time, frames_done, num_tests + 1);
    abort_run();
  end

endmodule

`default_nettype wire

// File: tilt_sensor_top.f
hw/tilt_pkg.sv
hw/spi_byte_engine.sv
hw/spi_cs_framer.sv
hw/accel_sequencer.sv
hw/tilt_display.sv
hw/tilt_sensor_top.sv
testbench/tilt_sensor_props.sv
testbench/tb_tilt_sensor.sv

// File: Makefile
# Verilator build and run of the tilt sensor testbench
TOP := tb_tilt_sensor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) \
		-f tilt_sensor_top.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: testbench/tilt_tests.txt
// One read frame per line, all hex
// Columns: sample byte (sign bit 7, magnitude bits 3:0), expected direction, expected segments
03 2 24 // Positive, above right limit
01 0 40 // Positive, below limit
02 0 40 // Positive, at limit
0F 2 24 // Positive, largest magnitude
80 1 79 // Negative, zero magnitude
8D 1 79 // Negative, just under left limit
8E 0 40 // Negative, at left limit
8F 0 40 // Negative, past left limit
7C 2 24 // Pad bits set, magnitude 12
70 0 40 // Pad bits set, magnitude 0
F5 1 79 // Negative with pad bits set
